//--- hdl/decodeUnit.sv
`timescale 1ns/1ps
`include "renameFrontEnd_config.svh"
`default_nettype none

module decodeUnit (
    input  renamePkg::fetchedInstr_t fetched,
    input  logic                     fetchEmpty,
    output logic                     fetchPop,

    output renamePkg::decodedOp_t    decoded,
    output logic                     decodePush,
    input  logic                     decodeFull
);

    // ----------------------------------------------------------
    // MIPS opcodes in the supported subset
    // ----------------------------------------------------------
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`LOG_ARCH-1:0]   rs;
    logic [`LOG_ARCH-1:0]   rt;
    logic [`LOG_ARCH-1:0]   rd;
    logic [15:0]            imm16;
    logic [`WORD_WIDTH-1:0] immSext;
    logic [`WORD_WIDTH-1:0] immZext;
    renamePkg::aluOp_t      rAluOp;

    assign opcode = fetched.instr[31:26];
    assign rs     = fetched.instr[25:21];
    assign rt     = fetched.instr[20:16];
    assign rd     = fetched.instr[15:11];
    assign imm16  = fetched.instr[15:0];
    assign funct  = fetched.instr[5:0];

    assign immSext = `WORD_WIDTH'($signed(imm16));
    assign immZext = `WORD_WIDTH'(imm16);

    // One op per cycle, straight from queue to queue
    assign fetchPop   = !fetchEmpty && !decodeFull;
    assign decodePush = fetchPop;

    // R-type function field
    always_comb begin
        case (funct)
            6'h20:   rAluOp = renamePkg::aluAdd;
            6'h22:   rAluOp = renamePkg::aluSub;
            6'h24:   rAluOp = renamePkg::aluAnd;
            6'h25:   rAluOp = renamePkg::aluOr;
            6'h2a:   rAluOp = renamePkg::aluSlt;
            default: rAluOp = renamePkg::aluNop;
        endcase
    end

    always_comb begin
        // Anything unrecognised stays a no-op with no register fields
        decoded       = '0;
        decoded.pc    = fetched.pc;
        decoded.aluOp = renamePkg::aluNop;

        case (opcode)
            opRType: begin
                if (rAluOp != renamePkg::aluNop) begin
                    decoded.aluOp    = rAluOp;
                    decoded.srcA     = rs;
                    decoded.srcB     = rt;
                    decoded.dst      = rd;
                    decoded.regWrite = 1'b1;
                end
            end
            opAddi, opAndi, opOri, opLw: begin
                decoded.srcA     = rs;
                decoded.dst      = rt;
                decoded.regWrite = 1'b1;
                decoded.hasImm   = 1'b1;
                decoded.memRead  = (opcode == opLw);
                if (opcode == opAndi) begin
                    decoded.aluOp = renamePkg::aluAnd;
                    decoded.imm   = immZext;
                end else if (opcode == opOri) begin
                    decoded.aluOp = renamePkg::aluOr;
                    decoded.imm   = immZext;
                end else begin
                    decoded.aluOp = renamePkg::aluAdd;
                    decoded.imm   = immSext;
                end
            end
            opSw: begin
                // Base in srcA, store data in srcB
                decoded.aluOp    = renamePkg::aluAdd;
                decoded.srcA     = rs;
                decoded.srcB     = rt;
                decoded.hasImm   = 1'b1;
                decoded.imm      = immSext;
                decoded.memWrite = 1'b1;
            end
            default: begin
                decoded.aluOp = renamePkg::aluNop;
            end
        endcase

        // Writes to $zero are dropped
        if (decoded.dst == '0) begin
            decoded.regWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetchUnit.sv
`timescale 1ns/1ps
`include "renameFrontEnd_config.svh"
`default_nettype none

module fetchUnit (
    input  logic                      clk,
    input  logic                      rstN,

    output logic [`WORD_WIDTH-1:0]    instrAddr,
    input  logic [`WORD_WIDTH-1:0]    instr,

    output renamePkg::fetchedInstr_t  fetched,
    output logic                      push,
    input  logic                      pushMustWait
);

    logic [`WORD_WIDTH-1:0] pc;
    // Set on the first edge after reset, keeps push quiet during reset
    logic                   running;

    assign instrAddr = pc;

    // Instruction memory answers in the same cycle
    assign fetched.instr = instr;
    assign fetched.pc    = pc;

    assign push = running && !pushMustWait;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            pc      <= '0;
        end else begin
            running <= 1'b1;
            // PC holds while the fetch queue is full
            if (push) begin
                pc <= pc + `WORD_WIDTH'(4);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/freeList.sv
`timescale 1ns/1ps
`include "renameFrontEnd_config.svh"
`default_nettype none

module freeList (
    input  logic                 clk,
    input  logic                 rstN,

    input  logic                 allocate,
    output logic [`LOG_PHYS-1:0] freeTag,
    output logic                 empty,

    input  logic                 retireValid,
    input  logic [`LOG_PHYS-1:0] retireReg
);

    logic [`LOG_PHYS-1:0] slots [`NUM_PHYS_REGS];
    // Pointers wrap on their own width
    logic [`LOG_PHYS-1:0] rdPtr;
    logic [`LOG_PHYS-1:0] wrPtr;
    logic [`LOG_PHYS:0]   count;
    logic                 doDeq;

    assign empty   = (count == '0);
    assign freeTag = slots[rdPtr];
    assign doDeq   = allocate && !empty;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // Slots 0 to 31 hold tags 32 to 63, the rest is outside count
            for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
                slots[i] <= `LOG_PHYS'(i + `NUM_ARCH_REGS);
            end
            rdPtr <= '0;
            wrPtr <= `LOG_PHYS'(`NUM_ARCH_REGS);
            count <= (`LOG_PHYS + 1)'(`NUM_PHYS_REGS - `NUM_ARCH_REGS);
        end else begin
            if (retireValid) begin
                slots[wrPtr] <= retireReg;
                wrPtr        <= wrPtr + 1'b1;
            end
            if (doDeq) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({retireValid, doDeq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/instrQueue.sv
`timescale 1ns/1ps
`default_nettype none

module instrQueue #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 8
) (
    input  logic     clk,
    input  logic     rstN,

    input  payload_t inData,
    input  logic     push,
    output logic     pushMustWait,

    output payload_t outData,
    input  logic     pop,
    output logic     popMustWait
);

    localparam int ptrW   = (depth > 1) ? $clog2(depth) : 1;
    localparam int countW = $clog2(depth + 1);

    payload_t          entries [depth];
    logic [ptrW-1:0]   rdPtr;
    logic [ptrW-1:0]   wrPtr;
    logic [countW-1:0] count;
    logic              doPush;
    logic              doPop;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pushMustWait = (count == countW'(depth));
    assign popMustWait  = (count == '0);

    assign doPush = push && !pushMustWait;
    assign doPop  = pop && !popMustWait;

    // Head is visible whenever the queue holds something
    assign outData = entries[rdPtr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= inData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/renameFrontEnd.sv
`timescale 1ns/1ps
`include "renameFrontEnd_config.svh"
`default_nettype none

module renameFrontEnd (
    input  logic                  clk,
    input  logic                  rstN,

    output logic [`WORD_WIDTH-1:0] instrAddr,
    input  logic [`WORD_WIDTH-1:0] instr,

    output logic                  renamedValid,
    output renamePkg::renamedOp_t renamedOp,
    input  logic                  renameStall,

    input  logic                  retireValid,
    input  logic [`LOG_PHYS-1:0]  retireReg
);

    // ----------------------------------------------------------
    // Fetch into the fetch queue
    // ----------------------------------------------------------
    renamePkg::fetchedInstr_t fetched;
    renamePkg::fetchedInstr_t fetchHead;
    logic                     fetchPush;
    logic                     fetchFull;
    logic                     fetchPop;
    logic                     fetchEmpty;

    fetchUnit fetch0 (
        .clk          (clk),
        .rstN         (rstN),
        .instrAddr    (instrAddr),
        .instr        (instr),
        .fetched      (fetched),
        .push         (fetchPush),
        .pushMustWait (fetchFull)
    );

    instrQueue #(
        .payload_t (renamePkg::fetchedInstr_t),
        .depth     (`FETCH_QUEUE_DEPTH)
    ) fetchQueue (
        .clk          (clk),
        .rstN         (rstN),
        .inData       (fetched),
        .push         (fetchPush),
        .pushMustWait (fetchFull),
        .outData      (fetchHead),
        .pop          (fetchPop),
        .popMustWait  (fetchEmpty)
    );

    // ----------------------------------------------------------
    // Decode into the decode queue
    // ----------------------------------------------------------
    renamePkg::decodedOp_t decoded;
    renamePkg::decodedOp_t decodeHead;
    logic                  decodePush;
    logic                  decodeFull;
    logic                  decodePop;
    logic                  decodeEmpty;

    decodeUnit decode0 (
        .fetched    (fetchHead),
        .fetchEmpty (fetchEmpty),
        .fetchPop   (fetchPop),
        .decoded    (decoded),
        .decodePush (decodePush),
        .decodeFull (decodeFull)
    );

    instrQueue #(
        .payload_t (renamePkg::decodedOp_t),
        .depth     (`DECODE_QUEUE_DEPTH)
    ) decodeQueue (
        .clk          (clk),
        .rstN         (rstN),
        .inData       (decoded),
        .push         (decodePush),
        .pushMustWait (decodeFull),
        .outData      (decodeHead),
        .pop          (decodePop),
        .popMustWait  (decodeEmpty)
    );

    // ----------------------------------------------------------
    // Rename and free list
    // ----------------------------------------------------------
    logic [`LOG_PHYS-1:0] freeTag;
    logic                 freeEmpty;
    logic                 allocate;

    renameUnit rename0 (
        .clk          (clk),
        .rstN         (rstN),
        .decoded      (decodeHead),
        .decodeEmpty  (decodeEmpty),
        .decodePop    (decodePop),
        .freeTag      (freeTag),
        .freeEmpty    (freeEmpty),
        .allocate     (allocate),
        .renamedOp    (renamedOp),
        .renamedValid (renamedValid),
        .renameStall  (renameStall)
    );

    // Retire strobe stands in for the reorder buffer
    freeList freeList0 (
        .clk         (clk),
        .rstN        (rstN),
        .allocate    (allocate),
        .freeTag     (freeTag),
        .empty       (freeEmpty),
        .retireValid (retireValid),
        .retireReg   (retireReg)
    );

endmodule

`default_nettype wire

//--- hdl/renameFrontEnd_config.svh
`ifndef RENAME_FRONT_END_CONFIG_SVH
`define RENAME_FRONT_END_CONFIG_SVH

`default_nettype none

// ----------------------------------------------------------
// Register file sizes
// ----------------------------------------------------------

// Architectural registers seen by the program
`define NUM_ARCH_REGS 32
`define LOG_ARCH 5

// Physical registers behind the alias table
// NUM_PHYS_REGS must stay a power of two, the free list wraps on it
`define NUM_PHYS_REGS 64
`define LOG_PHYS 6

// ----------------------------------------------------------
// Datapath and queues
// ----------------------------------------------------------

// Data and address width
`define WORD_WIDTH 32

// Queue depths between stages
`define FETCH_QUEUE_DEPTH 8
`define DECODE_QUEUE_DEPTH 8

`default_nettype wire

`endif

//--- hdl/renamePkg.sv
`include "renameFrontEnd_config.svh"
`default_nettype none

package renamePkg;

    // ALU operations understood by the back end
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluNop
    } aluOp_t;

    // Fetch to decode
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] instr;
        logic [`WORD_WIDTH-1:0] pc;
    } fetchedInstr_t;

    // Decode to rename, registers still architectural
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] pc;
        aluOp_t                 aluOp;
        logic [`LOG_ARCH-1:0]   srcA;
        logic [`LOG_ARCH-1:0]   srcB;
        logic [`LOG_ARCH-1:0]   dst;
        logic                   regWrite;
        logic                   hasImm;
        logic [`WORD_WIDTH-1:0] imm;
        logic                   memRead;
        logic                   memWrite;
    } decodedOp_t;

    // Rename output, registers as physical tags
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] pc;
        aluOp_t                 aluOp;
        logic [`LOG_PHYS-1:0]   srcAPhys;
        logic [`LOG_PHYS-1:0]   srcBPhys;
        logic [`LOG_PHYS-1:0]   dstPhys;
        // Previous mapping of the destination, freed when this op retires
        logic [`LOG_PHYS-1:0]   oldDstPhys;
        logic                   regWrite;
        logic                   hasImm;
        logic [`WORD_WIDTH-1:0] imm;
        logic                   memRead;
        logic                   memWrite;
    } renamedOp_t;

endpackage

`default_nettype wire

//--- hdl/renameUnit.sv
`timescale 1ns/1ps
`include "renameFrontEnd_config.svh"
`default_nettype none

module renameUnit (
    input  logic                  clk,
    input  logic                  rstN,

    input  renamePkg::decodedOp_t decoded,
    input  logic                  decodeEmpty,
    output logic                  decodePop,

    input  logic [`LOG_PHYS-1:0]  freeTag,
    input  logic                  freeEmpty,
    output logic                  allocate,

    output renamePkg::renamedOp_t renamedOp,
    output logic                  renamedValid,
    input  logic                  renameStall
);

    // Front-end alias table
    logic [`LOG_PHYS-1:0]  aliasTable [`NUM_ARCH_REGS];
    renamePkg::renamedOp_t nextOp;
    logic                  outFree;

    // ----------------------------------------------------------
    // Pop rule
    // ----------------------------------------------------------

    // Output register empty or leaving this cycle
    assign outFree = !renamedValid || !renameStall;

    assign decodePop = !decodeEmpty && outFree && (!decoded.regWrite || !freeEmpty);
    assign allocate  = decodePop && decoded.regWrite;

    // ----------------------------------------------------------
    // Mapping lookup
    // ----------------------------------------------------------

    // Reads see the table before this cycle's update
    always_comb begin
        nextOp.pc         = decoded.pc;
        nextOp.aluOp      = decoded.aluOp;
        nextOp.srcAPhys   = aliasTable[decoded.srcA];
        nextOp.srcBPhys   = aliasTable[decoded.srcB];
        nextOp.dstPhys    = decoded.regWrite ? freeTag : '0;
        nextOp.oldDstPhys = aliasTable[decoded.dst];
        nextOp.regWrite   = decoded.regWrite;
        nextOp.hasImm     = decoded.hasImm;
        nextOp.imm        = decoded.imm;
        nextOp.memRead    = decoded.memRead;
        nextOp.memWrite   = decoded.memWrite;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                aliasTable[i] <= `LOG_PHYS'(i);
            end
            renamedValid <= 1'b0;
        end else begin
            if (allocate) begin
                aliasTable[decoded.dst] <= freeTag;
            end
            // Held op stays valid under stall
            if (outFree) begin
                renamedValid <= decodePop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decodePop) begin
            renamedOp <= nextOp;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the rename front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module renameFrontEnd_tb

# Show the simulation output and fail unless the pass message appears
./obj_dir/VrenameFrontEnd_tb | tee /dev/stderr | grep "TEST PASS" > /dev/null

echo "Simulation passed"

//--- tb.f
+incdir+hdl
hdl/renamePkg.sv
hdl/instrQueue.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/freeList.sv
hdl/renameUnit.sv
hdl/renameFrontEnd.sv
tests/renameFrontEnd_assert.sv
tests/renameFrontEnd_tb.sv

//--- tests/renameFrontEnd_assert.sv
`timescale 1ns/1ps
`include "renameFrontEnd_config.svh"
`default_nettype none

module renameFrontEndAssert (
    input logic                  clk,
    input logic                  rstN,
    input logic                  renamedValid,
    input renamePkg::renamedOp_t renamedOp,
    input logic                  renameStall,
    input logic                  allocate,
    input logic                  freeEmpty
);

    int unsigned failCount = 0;
    // Allocations since reset, stops counting past the initial pool
    logic [`LOG_PHYS:0] allocCount;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            allocCount <= '0;
        end else if (allocate && allocCount <= (`LOG_PHYS + 1)'(`NUM_ARCH_REGS)) begin
            allocCount <= allocCount + 1'b1;
        end
    end

    holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
        renamedValid && renameStall |=> $stable(renamedOp))
    else begin
        failCount++;
        $error("renamedOp changed while held under stall");
    end

    noAllocWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        !(allocate && freeEmpty))
    else begin
        failCount++;
        $error("Allocation from an empty free list");
    end

    // First pool hands out tags 32 and up only
    spareTagsFirst: assert property (@(posedge clk) disable iff (!rstN)
        renamedValid && renamedOp.regWrite && allocCount <= (`LOG_PHYS + 1)'(`NUM_ARCH_REGS)
        |-> renamedOp.dstPhys >= `LOG_PHYS'(`NUM_ARCH_REGS))
    else begin
        failCount++;
        $error("Destination tag below 32 during the first allocations");
    end

endmodule

bind renameFrontEnd renameFrontEndAssert assert0 (
    .clk          (clk),
    .rstN         (rstN),
    .renamedValid (renamedValid),
    .renamedOp    (renamedOp),
    .renameStall  (renameStall),
    .allocate     (allocate),
    .freeEmpty    (freeEmpty)
);

`default_nettype wire

//--- tests/renameFrontEnd_tb.sv
`timescale 1ns/1ps
`include "renameFrontEnd_config.svh"
`default_nettype none

module renameFrontEnd_tb;

    localparam int numEntries = 41;
    localparam int waitLimit  = 200;
    localparam int idleCycles = 50;

    // One program word with its expected decode
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] instrWord;
        renamePkg::aluOp_t      aluOp;
        logic [`LOG_ARCH-1:0]   srcA;
        logic [`LOG_ARCH-1:0]   srcB;
        logic [`LOG_ARCH-1:0]   dst;
        logic                   regWrite;
        logic                   hasImm;
        logic [`WORD_WIDTH-1:0] imm;
        logic                   memRead;
        logic                   memWrite;
    } progEntry_t;

    logic                   clk;
    logic                   rstN;
    logic [`WORD_WIDTH-1:0] instrAddr;
    logic [`WORD_WIDTH-1:0] instr;
    logic                   renamedValid;
    renamePkg::renamedOp_t  renamedOp;
    logic                   renameStall;
    logic                   retireValid;
    logic [`LOG_PHYS-1:0]   retireReg;

    progEntry_t            progTable [numEntries];
    string                 progName  [numEntries];
    renamePkg::renamedOp_t firstRun  [numEntries];
    renamePkg::renamedOp_t received  [$];
    int                    tableSize;

    // Reference rename state
    logic [`LOG_PHYS-1:0] refMap [`NUM_ARCH_REGS];
    logic [`LOG_PHYS-1:0] refFree [$];

    logic [31:0] rngState;
    bit          randomStall;
    bit          timedOut;
    int          checkErrors;
    int          timeouts;

    renameFrontEnd dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .instrAddr    (instrAddr),
        .instr        (instr),
        .renamedValid (renamedValid),
        .renamedOp    (renamedOp),
        .renameStall  (renameStall),
        .retireValid  (retireValid),
        .retireReg    (retireReg)
    );

    always #5 clk = ~clk;

    // Instruction memory returns zero past the program
    assign instr = (instrAddr[31:2] < 30'(numEntries)) ? progTable[instrAddr[7:2]].instrWord : '0;

    // ----------------------------------------------------------
    // Encoding and random helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] rWord(input logic [5:0] funct, input int rs, input int rt,
                                          input int rd);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm16);
        return {op, 5'(rs), 5'(rt), imm16};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic addEntry(input string name, input logic [31:0] word,
                            input renamePkg::aluOp_t op, input int srcA, input int srcB,
                            input int dst, input bit rw, input bit hi, input logic [31:0] imm,
                            input bit mr, input bit mw);
        progName[tableSize]  = name;
        progTable[tableSize] = {word, op, 5'(srcA), 5'(srcB), 5'(dst), rw, hi, imm, mr, mw};
        tableSize++;
    endtask

    // ----------------------------------------------------------
    // Program table
    // ----------------------------------------------------------
    task automatic buildTable();
        int d;
        tableSize = 0;
        addEntry("add", rWord(6'h20, 1, 2, 3), renamePkg::aluAdd, 1, 2, 3, 1, 0, 0, 0, 0);
        addEntry("sub", rWord(6'h22, 3, 1, 4), renamePkg::aluSub, 3, 1, 4, 1, 0, 0, 0, 0);
        addEntry("and", rWord(6'h24, 3, 4, 5), renamePkg::aluAnd, 3, 4, 5, 1, 0, 0, 0, 0);
        addEntry("or", rWord(6'h25, 4, 5, 6), renamePkg::aluOr, 4, 5, 6, 1, 0, 0, 0, 0);
        addEntry("slt", rWord(6'h2a, 5, 6, 7), renamePkg::aluSlt, 5, 6, 7, 1, 0, 0, 0, 0);
        addEntry("addi neg", iWord(6'h08, 7, 8, 16'hfffb), renamePkg::aluAdd,
                 7, 0, 8, 1, 1, 32'hffff_fffb, 0, 0);
        addEntry("andi high", iWord(6'h0c, 8, 9, 16'h8001), renamePkg::aluAnd,
                 8, 0, 9, 1, 1, 32'h0000_8001, 0, 0);
        addEntry("ori high", iWord(6'h0d, 9, 10, 16'hff00), renamePkg::aluOr,
                 9, 0, 10, 1, 1, 32'h0000_ff00, 0, 0);
        addEntry("lw", iWord(6'h23, 10, 11, 16'h0010), renamePkg::aluAdd,
                 10, 0, 11, 1, 1, 32'h0000_0010, 1, 0);
        addEntry("sw neg", iWord(6'h2b, 3, 11, 16'hfff8), renamePkg::aluAdd,
                 3, 11, 0, 0, 1, 32'hffff_fff8, 0, 1);
        addEntry("zero word", 32'h0, renamePkg::aluNop, 0, 0, 0, 0, 0, 0, 0, 0);
        addEntry("add to r0", rWord(6'h20, 1, 2, 0), renamePkg::aluAdd, 1, 2, 0, 0, 0, 0, 0, 0);
        addEntry("addi self", iWord(6'h08, 3, 3, 16'h0001), renamePkg::aluAdd,
                 3, 0, 3, 1, 1, 32'h1, 0, 0);
        addEntry("add self", rWord(6'h20, 3, 3, 3), renamePkg::aluAdd, 3, 3, 3, 1, 0, 0, 0, 0);
        addEntry("nor", rWord(6'h27, 1, 2, 12), renamePkg::aluNop, 0, 0, 0, 0, 0, 0, 0, 0);
        addEntry("jump", 32'h0800_0010, renamePkg::aluNop, 0, 0, 0, 0, 0, 0, 0, 0);
        addEntry("addi r0", iWord(6'h08, 5, 0, 16'h0007), renamePkg::aluAdd,
                 5, 0, 0, 0, 1, 32'h7, 0, 0);
        addEntry("sw", iWord(6'h2b, 5, 4, 16'h0004), renamePkg::aluAdd, 5, 4, 0, 0, 1, 4, 0, 1);
        // Writer chain wraps back onto r12 to r14 near the end
        for (int k = 0; k < 23; k++) begin
            d = 12 + (k % 20);
            if (k % 2 == 0) begin
                addEntry($sformatf("add chain %0d", k), rWord(6'h20, d - 1, d - 2, d),
                         renamePkg::aluAdd, d - 1, d - 2, d, 1, 0, 0, 0, 0);
            end else begin
                addEntry($sformatf("ori chain %0d", k), iWord(6'h0d, d - 1, d, 16'(16'h8000 + k)),
                         renamePkg::aluOr, d - 1, 0, d, 1, 1, 32'h8000 + k, 0, 0);
            end
        end
    endtask

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic checkField(input string name, input string field, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            checkErrors++;
            $display("** Error %s %s: expected %0h, actual %0h", name, field, expVal, actVal);
        end
    endtask

    task automatic checkIdle(input string name);
        checkField(name, "renamedValid", 32'd0, 32'(renamedValid));
        checkField(name, "instrAddr", 32'd0, instrAddr);
    endtask

    task automatic checkOutput(input int idx, input renamePkg::renamedOp_t op, input int pass);
        progEntry_t           e;
        string                name;
        logic [`LOG_PHYS-1:0] expDst;
        e    = progTable[idx];
        name = progName[idx];
        checkField(name, "pc", 32'(idx * 4), op.pc);
        checkField(name, "aluOp", 32'(e.aluOp), 32'(op.aluOp));
        checkField(name, "regWrite", 32'(e.regWrite), 32'(op.regWrite));
        checkField(name, "hasImm", 32'(e.hasImm), 32'(op.hasImm));
        checkField(name, "imm", e.imm, op.imm);
        checkField(name, "memRead", 32'(e.memRead), 32'(op.memRead));
        checkField(name, "memWrite", 32'(e.memWrite), 32'(op.memWrite));
        checkField(name, "srcAPhys", 32'(refMap[e.srcA]), 32'(op.srcAPhys));
        checkField(name, "srcBPhys", 32'(refMap[e.srcB]), 32'(op.srcBPhys));
        checkField(name, "oldDstPhys", 32'(refMap[e.dst]), 32'(op.oldDstPhys));
        if (e.regWrite) begin
            expDst = refFree.pop_front();
            checkField(name, "dstPhys", 32'(expDst), 32'(op.dstPhys));
            refMap[e.dst] = expDst;
        end
        if (pass == 0) begin
            firstRun[idx] = op;
        end else begin
            assert (op === firstRun[idx]) else begin
                checkErrors++;
                $display("** Error %s stalled run: expected %h, actual %h",
                         name, firstRun[idx], op);
            end
        end
    endtask

    // ----------------------------------------------------------
    // Cycle driving and waits
    // ----------------------------------------------------------
    task automatic stepCycle(input bit retire, input logic [`LOG_PHYS-1:0] tag);
        @(posedge clk);
        #1;
        retireValid = retire;
        retireReg   = tag;
        if (randomStall) begin
            rngState    = xorshift(rngState);
            renameStall = rngState[3];
        end else begin
            renameStall = 1'b0;
        end
        @(negedge clk);
        if (renamedValid && !renameStall) begin
            received.push_back(renamedOp);
        end
    endtask

    task automatic waitAccept(output renamePkg::renamedOp_t op);
        int cycles;
        cycles = 0;
        while (received.size() == 0 && !timedOut) begin
            stepCycle(1'b0, '0);
            cycles++;
            if (received.size() == 0 && cycles >= waitLimit) begin
                timedOut = 1'b1;
                timeouts++;
                $display("Timeout: no renamed operation accepted within %0d cycles", waitLimit);
            end
        end
        if (timedOut) begin
            op = '0;
        end else begin
            op = received.pop_front();
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        rstN        = 1'b0;
        renameStall = 1'b0;
        retireValid = 1'b0;
        retireReg   = '0;
        repeat (2) begin
            @(negedge clk);
            checkIdle("reset held");
            @(posedge clk);
        end
        #1;
        rstN = 1'b1;
        // First active edge leaves the PC and the output register at rest
        @(posedge clk);
        @(negedge clk);
        checkIdle("first cycle after reset");
    endtask

    // Writers stay blocked on a dry free list until two tags come back
    task automatic exhaustAndRetire();
        for (int c = 0; c < idleCycles; c++) begin
            stepCycle(1'b0, '0);
            assert (!(renamedValid && renamedOp.regWrite)) else begin
                checkErrors++;
                $display("A writing operation was renamed while no free register was left");
            end
        end
        stepCycle(1'b1, `LOG_PHYS'(40));
        stepCycle(1'b1, `LOG_PHYS'(35));
        refFree.push_back(`LOG_PHYS'(40));
        refFree.push_back(`LOG_PHYS'(35));
    endtask

    task automatic runPass(input int pass);
        renamePkg::renamedOp_t op;
        bit                    retired;
        randomStall = (pass != 0);
        retired     = 1'b0;
        received.delete();
        refFree.delete();
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            refMap[i] = `LOG_PHYS'(i);
        end
        for (int t = `NUM_ARCH_REGS; t < `NUM_PHYS_REGS; t++) begin
            refFree.push_back(`LOG_PHYS'(t));
        end
        applyReset();
        for (int i = 0; i < numEntries && !timedOut; i++) begin
            if (progTable[i].regWrite && refFree.size() == 0 && !retired) begin
                exhaustAndRetire();
                retired = 1'b1;
            end
            waitAccept(op);
            if (!timedOut) begin
                checkOutput(i, op, pass);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        renameStall = 1'b0;
        retireValid = 1'b0;
        retireReg   = '0;
        rngState    = 32'd81384;
        randomStall = 1'b0;
        timedOut    = 1'b0;
        checkErrors = 0;
        timeouts    = 0;
        buildTable();
        // Pass 0 runs without stall and pass 1 with random stall
        runPass(0);
        if (!timedOut) begin
            runPass(1);
        end
        $display("Errors: %0d value checks, %0d timeouts, %0d assertions",
                 checkErrors, timeouts, dut0.assert0.failCount);
        if (checkErrors == 0 && timeouts == 0 && dut0.assert0.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
